//--- Bender.yml
package:
  name: command_issue

sources:
  - capi_pkg.sv
  - command_pkg.sv
  - command_dispatch.sv
  - command_buffer.sv
  - command_arbiter.sv
  - command_control.sv
  - command_issue_top.sv
  - target: test
    files:
      - tb_command_issue.sv

//--- capi_pkg.sv
package capi_pkg;

  ////////////////////
  // host bus field widths
  ////////////////////

  typedef logic [12:0] command_code_t;    // psl command opcode
  typedef logic [63:0] address_t;         // effective address
  typedef logic [11:0] size_t;            // transfer size in bytes
  typedef logic [7:0]  tag_t;             // command tag
  typedef logic [2:0]  abt_t;             // abort / translation mode
  typedef logic [15:0] context_handle_t;  // cch

  ////////////////////
  // abort modes
  ////////////////////

  // strict is the only mode used in dedicated mode
  localparam abt_t STRICT = 3'b000;

  ////////////////////
  // command codes
  ////////////////////

  localparam command_code_t INVALID    = 13'h0000;  // idle bus
  localparam command_code_t READ_CL_NA = 13'h0A00;  // read cache line, no allocate
  localparam command_code_t WRITE_NA   = 13'h0D00;  // write, no allocate
  localparam command_code_t RESTART    = 13'h0001;  // restart after error

  localparam tag_t INVALID_TAG = 8'hFF;  // no command outstanding

  ////////////////////
  // parity
  ////////////////////

  // odd parity over a field up to 64 bits wide
  // narrower fields are zero extended, which leaves the count of ones alone
  // returns 1 when the field holds an even number of ones
  function automatic logic odd_parity(input logic [63:0] data);
    return ~(^data);
  endfunction

endpackage

//--- command_arbiter.sv
`timescale 1ns/1ns

module command_arbiter (
  input  logic                                                      clock,
  input  logic                                                      rstn,
  input  logic                                                      enabled,
  input  logic [command_pkg::CLASS_COUNT-1:0]                       ready,
  input  capi_pkg::command_code_t [command_pkg::CLASS_COUNT-1:0]    head_command,
  input  capi_pkg::address_t [command_pkg::CLASS_COUNT-1:0]         head_address,
  input  capi_pkg::size_t [command_pkg::CLASS_COUNT-1:0]            head_size,
  input  capi_pkg::tag_t [command_pkg::CLASS_COUNT-1:0]             head_tag,
  output logic [command_pkg::CLASS_COUNT-1:0]                       pop,
  output logic                                                      select_valid,
  output capi_pkg::command_code_t                                   select_command,
  output capi_pkg::address_t                                        select_address,
  output capi_pkg::size_t                                           select_size,
  output capi_pkg::tag_t                                            select_tag
);

  import command_pkg::*;

  class_t   ptr_q;        // first class searched this cycle
  class_t   grant;        // winning class
  class_t   idx;          // search position
  logic     grant_found;  // some queue is ready

  ////////////////////
  // round robin search
  ////////////////////

  always_comb begin
    grant_found = 1'b0;
    grant       = ptr_q;
    idx         = ptr_q;
    for (int k = 0; k < CLASS_COUNT; k++) begin
      idx = ptr_q + class_t'(k);  // wraps around the classes
      if (!grant_found && ready[idx]) begin
        grant_found = 1'b1;
        grant       = idx;
      end
    end
  end

  assign select_valid = enabled && grant_found;  // silent while disabled
  assign pop          = select_valid ? (CLASS_COUNT'(1) << grant) : '0;

  // head of the winner, don't care when not valid
  assign select_command = head_command[grant];
  assign select_address = head_address[grant];
  assign select_size    = head_size[grant];
  assign select_tag     = head_tag[grant];

  // pointer moves past the class just served
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      ptr_q <= CLASS_RESTART;
    end else if (select_valid) begin
      ptr_q <= grant + 1'b1;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  a_pop_onehot : assert property (@(posedge clock) disable iff (!rstn)
    $onehot0(pop));

  // tag built by the dispatcher names the queue it came out of
  a_tag_matches_queue : assert property (@(posedge clock) disable iff (!rstn)
    select_valid |-> (tag_class(select_tag) == grant));

endmodule

//--- command_buffer.sv
`timescale 1ns/1ns

module command_buffer (
  input  logic                      clock,
  input  logic                      rstn,
  input  logic                      push,
  input  capi_pkg::command_code_t   push_command,
  input  capi_pkg::address_t        push_address,
  input  capi_pkg::size_t           push_size,
  input  capi_pkg::tag_t            push_tag,
  input  logic                      pop,
  output logic                      ready,
  output logic                      full,
  output capi_pkg::command_code_t   head_command,
  output capi_pkg::address_t        head_address,
  output capi_pkg::size_t           head_size,
  output capi_pkg::tag_t            head_tag
);

  import capi_pkg::*;
  import command_pkg::*;

  // entry storage
  command_code_t  command_mem [QUEUE_DEPTH];
  address_t       address_mem [QUEUE_DEPTH];
  size_t          size_mem    [QUEUE_DEPTH];
  tag_t           tag_mem     [QUEUE_DEPTH];

  queue_ptr_t     wr_ptr_q;
  queue_ptr_t     rd_ptr_q;
  queue_count_t   count_q;

  ////////////////////
  // pointers and occupancy
  ////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;  // natural wrap, depth is 4
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // both or neither
      endcase
    end
  end

  // write port
  always_ff @(posedge clock) begin
    if (push) begin
      command_mem[wr_ptr_q] <= push_command;
      address_mem[wr_ptr_q] <= push_address;
      size_mem[wr_ptr_q]    <= push_size;
      tag_mem[wr_ptr_q]     <= push_tag;
    end
  end

  ////////////////////
  // head and levels
  ////////////////////

  assign ready = (count_q != '0);
  assign full  = (count_q == queue_count_t'(QUEUE_DEPTH));

  assign head_command = command_mem[rd_ptr_q];
  assign head_address = address_mem[rd_ptr_q];
  assign head_size    = size_mem[rd_ptr_q];
  assign head_tag     = tag_mem[rd_ptr_q];

  ////////////////////
  // checks
  ////////////////////

  // arbiter only pops a non-empty queue
  a_no_pop_empty : assert property (@(posedge clock) disable iff (!rstn)
    pop |-> ready);

  // dispatcher holds back pushes to a full queue
  a_no_push_full : assert property (@(posedge clock) disable iff (!rstn)
    push |-> !full);

endmodule

//--- command_control.sv
`timescale 1ns/1ns

module command_control (
  input  logic                        clock,
  input  logic                        rstn,
  input  logic                        select_valid,
  input  capi_pkg::command_code_t     select_command,
  input  capi_pkg::address_t          select_address,
  input  capi_pkg::size_t             select_size,
  input  capi_pkg::tag_t              select_tag,
  output logic                        command_valid,
  output capi_pkg::command_code_t     command_code,
  output capi_pkg::address_t          command_address,
  output capi_pkg::tag_t              command_tag,
  output capi_pkg::size_t             command_size,
  output capi_pkg::abt_t              command_abt,
  output capi_pkg::context_handle_t   command_context_handle,
  output logic                        command_tag_parity,
  output logic                        command_code_parity,
  output logic                        command_address_parity
);

  import capi_pkg::*;

  command_code_t  next_code;
  address_t       next_address;
  tag_t           next_tag;
  size_t          next_size;

  // dedicated mode constants
  assign command_abt            = STRICT;
  assign command_context_handle = '0;

  ////////////////////
  // idle fill
  ////////////////////

  assign next_code    = select_valid ? select_command : INVALID;
  assign next_address = select_valid ? select_address : '0;
  assign next_tag     = select_valid ? select_tag     : INVALID_TAG;
  assign next_size    = select_valid ? select_size    : '0;

  ////////////////////
  // outward register
  ////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      command_valid          <= 1'b0;
      command_code           <= INVALID;
      command_address        <= '0;
      command_tag            <= INVALID_TAG;
      command_size           <= '0;
      command_tag_parity     <= odd_parity(INVALID_TAG);  // parity of idle values
      command_code_parity    <= odd_parity(INVALID);
      command_address_parity <= odd_parity('0);
    end else begin
      command_valid          <= select_valid;
      command_code           <= next_code;
      command_address        <= next_address;
      command_tag            <= next_tag;
      command_size           <= next_size;
      command_tag_parity     <= odd_parity(next_tag);  // generated ahead of the flop
      command_code_parity    <= odd_parity(next_code);
      command_address_parity <= odd_parity(next_address);
    end
  end

  a_bus_parity : assert property (@(posedge clock) disable iff (!rstn)
    (command_tag_parity == odd_parity(command_tag)) &&
    (command_code_parity == odd_parity(command_code)) &&
    (command_address_parity == odd_parity(command_address)));

endmodule

//--- command_dispatch.sv
`timescale 1ns/1ns

module command_dispatch (
  input  logic                                  clock,
  input  logic                                  rstn,
  input  logic                                  request_valid,
  input  command_pkg::class_t                   request_class,
  input  capi_pkg::command_code_t               request_command,
  input  capi_pkg::address_t                    request_address,
  input  capi_pkg::size_t                       request_size,
  input  logic [command_pkg::CLASS_COUNT-1:0]   full,
  output logic [command_pkg::CLASS_COUNT-1:0]   push,
  output capi_pkg::command_code_t               push_command,
  output capi_pkg::address_t                    push_address,
  output capi_pkg::size_t                       push_size,
  output capi_pkg::tag_t                        push_tag,
  output logic                                  request_dropped
);

  import capi_pkg::*;
  import command_pkg::*;

  logic [CLASS_COUNT-1:0]   hit;    // decoded target queue
  seq_t [CLASS_COUNT-1:0]   seq_q;  // next sequence per class

  ////////////////////
  // class decode
  ////////////////////

  assign hit  = request_valid ? (CLASS_COUNT'(1) << request_class) : '0;
  assign push = hit & ~full;  // full queue swallows nothing

  // same cycle drop flag
  assign request_dropped = |(hit & full);

  // fields fan out to every queue, only the pushed one takes them
  assign push_command = request_command;
  assign push_address = request_address;
  assign push_size    = request_size;
  assign push_tag     = tag_t'(make_tag(request_class, seq_q[request_class]));

  ////////////////////
  // sequence counters
  ////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      seq_q <= '0;
    end else begin
      for (int i = 0; i < CLASS_COUNT; i++) begin
        if (push[i]) begin
          seq_q[i] <= seq_q[i] + 1'b1;  // wraps at 64
        end
      end
    end
  end

  ////////////////////
  // checks
  ////////////////////

  a_push_onehot : assert property (@(posedge clock) disable iff (!rstn)
    $onehot0(push));

endmodule

//--- command_issue_top.sv
`timescale 1ns/1ns

module command_issue_top (
  input  logic                                clock,
  input  logic                                rstn,
  input  logic                                request_valid,
  input  command_pkg::class_t                 request_class,
  input  capi_pkg::command_code_t             request_command,
  input  capi_pkg::address_t                  request_address,
  input  capi_pkg::size_t                     request_size,
  input  logic                                enabled,
  output logic [command_pkg::CLASS_COUNT-1:0] request_full,
  output logic                                request_dropped,
  output logic                                command_valid,
  output capi_pkg::command_code_t             command_code,
  output capi_pkg::address_t                  command_address,
  output capi_pkg::tag_t                      command_tag,
  output capi_pkg::size_t                     command_size,
  output capi_pkg::abt_t                      command_abt,
  output capi_pkg::context_handle_t           command_context_handle,
  output logic                                command_tag_parity,
  output logic                                command_code_parity,
  output logic                                command_address_parity
);

  import capi_pkg::*;
  import command_pkg::*;

  ////////////////////
  // dispatch to queues
  ////////////////////

  logic [CLASS_COUNT-1:0]   push;
  command_code_t            push_command;
  address_t                 push_address;
  size_t                    push_size;
  tag_t                     push_tag;

  // queue heads toward the arbiter
  logic [CLASS_COUNT-1:0]            pop;
  logic [CLASS_COUNT-1:0]            ready;
  command_code_t [CLASS_COUNT-1:0]   head_command;
  address_t [CLASS_COUNT-1:0]        head_address;
  size_t [CLASS_COUNT-1:0]           head_size;
  tag_t [CLASS_COUNT-1:0]            head_tag;

  // arbiter to control
  logic           select_valid;
  command_code_t  select_command;
  address_t       select_address;
  size_t          select_size;
  tag_t           select_tag;

  command_dispatch command_dispatch_i (
    .clock           (clock),
    .rstn            (rstn),
    .request_valid   (request_valid),
    .request_class   (request_class),
    .request_command (request_command),
    .request_address (request_address),
    .request_size    (request_size),
    .full            (request_full),
    .push            (push),
    .push_command    (push_command),
    .push_address    (push_address),
    .push_size       (push_size),
    .push_tag        (push_tag),
    .request_dropped (request_dropped)
  );

  ////////////////////
  // one queue per class
  ////////////////////

  for (genvar i = 0; i < CLASS_COUNT; i++) begin : g_queue
    command_buffer command_buffer_i (
      .clock        (clock),
      .rstn         (rstn),
      .push         (push[i]),
      .push_command (push_command),
      .push_address (push_address),
      .push_size    (push_size),
      .push_tag     (push_tag),
      .pop          (pop[i]),
      .ready        (ready[i]),
      .full         (request_full[i]),
      .head_command (head_command[i]),
      .head_address (head_address[i]),
      .head_size    (head_size[i]),
      .head_tag     (head_tag[i])
    );
  end

  command_arbiter command_arbiter_i (
    .clock          (clock),
    .rstn           (rstn),
    .enabled        (enabled),
    .ready          (ready),
    .head_command   (head_command),
    .head_address   (head_address),
    .head_size      (head_size),
    .head_tag       (head_tag),
    .pop            (pop),
    .select_valid   (select_valid),
    .select_command (select_command),
    .select_address (select_address),
    .select_size    (select_size),
    .select_tag     (select_tag)
  );

  ////////////////////
  // outward bus
  ////////////////////

  command_control command_control_i (
    .clock                  (clock),
    .rstn                   (rstn),
    .select_valid           (select_valid),
    .select_command         (select_command),
    .select_address         (select_address),
    .select_size            (select_size),
    .select_tag             (select_tag),
    .command_valid          (command_valid),
    .command_code           (command_code),
    .command_address        (command_address),
    .command_tag            (command_tag),
    .command_size           (command_size),
    .command_abt            (command_abt),
    .command_context_handle (command_context_handle),
    .command_tag_parity     (command_tag_parity),
    .command_code_parity    (command_code_parity),
    .command_address_parity (command_address_parity)
  );

endmodule

//--- command_pkg.sv
package command_pkg;

  ////////////////////
  // request classes
  ////////////////////

  localparam int CLASS_COUNT = 4;
  localparam int CLASS_BITS  = 2;

  typedef logic [CLASS_BITS-1:0] class_t;

  // value is also the queue index and the arbitration order
  localparam class_t CLASS_RESTART = 2'd0;
  localparam class_t CLASS_WED     = 2'd1;
  localparam class_t CLASS_WRITE   = 2'd2;
  localparam class_t CLASS_READ    = 2'd3;

  ////////////////////
  // per class queue
  ////////////////////

  localparam int QUEUE_DEPTH = 4;

  typedef logic [1:0] queue_ptr_t;    // wraps at QUEUE_DEPTH
  typedef logic [2:0] queue_count_t;  // 0 .. QUEUE_DEPTH

  ////////////////////
  // tag layout
  ////////////////////

  localparam int SEQ_BITS = 6;
  localparam int TAG_BITS = CLASS_BITS + SEQ_BITS;  // matches the host tag

  typedef logic [SEQ_BITS-1:0] seq_t;

  // class in the top bits, per class sequence below
  function automatic logic [TAG_BITS-1:0] make_tag(input class_t cls, input seq_t seq);
    return {cls, seq};
  endfunction

  function automatic class_t tag_class(input logic [TAG_BITS-1:0] tag);
    return tag[TAG_BITS-1 -: CLASS_BITS];
  endfunction

endpackage

//--- files.f
capi_pkg.sv
command_pkg.sv
command_dispatch.sv
command_buffer.sv
command_arbiter.sv
command_control.sv
command_issue_top.sv
tb_command_issue.sv

//--- tb_command_issue.sv
`timescale 1ns/1ns

module tb_command_issue;

  import capi_pkg::*;
  import command_pkg::*;

  localparam int RANDOM_CYCLES = 120;
  // reset, random, parity, fairness, drop, pause, then margin
  localparam int CYCLE_LIMIT = 8 + 2 * RANDOM_CYCLES + 40 + 60 + 50 + 60 + 200;

  logic                     clock;
  logic                     rstn;
  logic                     request_valid;
  class_t                   request_class;
  command_code_t            request_command;
  address_t                 request_address;
  size_t                    request_size;
  logic                     enabled;
  logic [CLASS_COUNT-1:0]   request_full;
  logic                     request_dropped;
  logic                     command_valid;
  command_code_t            command_code;
  address_t                 command_address;
  tag_t                     command_tag;
  size_t                    command_size;
  abt_t                     command_abt;
  context_handle_t          command_context_handle;
  logic                     command_tag_parity;
  logic                     command_code_parity;
  logic                     command_address_parity;

  // scoreboard, one expected queue per class
  command_code_t  exp_code    [CLASS_COUNT][$];
  address_t       exp_address [CLASS_COUNT][$];
  size_t          exp_size    [CLASS_COUNT][$];
  tag_t           exp_tag     [CLASS_COUNT][$];
  int             model_count [CLASS_COUNT];  // occupancy, pops of last cycle pending
  int             seq_next    [CLASS_COUNT];  // not advanced on drops

  logic [CLASS_COUNT-1:0]   issuing;
  logic [CLASS_COUNT-1:0]   accepting;
  logic [CLASS_COUNT-1:0]   expected_full;
  logic                     expected_drop;

  logic [31:0]  lfsr_state;
  int           error_count;
  int           errors_at_start;
  int           test_count;
  int           dropped_seen;
  int           drops_before;
  int           cycle_count;
  logic         fair_armed;
  int           fair_issues;
  class_t       fair_hist [3];  // last three issued classes

  command_issue_top command_issue_top_i (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  ////////////////////
  // helpers
  ////////////////////

  // galois lfsr, one step per bit
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] value;
    logic        bit_out;
    value = '0;
    for (int i = 0; i < n; i++) begin
      bit_out    = lfsr_state[0];
      lfsr_state = (lfsr_state >> 1) ^ (bit_out ? 32'h8020_0003 : 32'h0);
      value      = {value[62:0], bit_out};
    end
    return value;
  endfunction

  // 1 when the field alone has an even count of ones
  function automatic logic expect_parity(input logic [63:0] field);
    int ones;
    ones = 0;
    for (int i = 0; i < 64; i++) ones += field[i];
    return (ones % 2) == 0;
  endfunction

  function automatic int outstanding();
    int total;
    total = 0;
    for (int c = 0; c < CLASS_COUNT; c++) total += exp_tag[c].size();
    return total;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
    $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, expected);
    error_count++;
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t ns: %s", $time, what);
    error_count++;
  endtask

  task automatic finish_test(input string name);
    test_count++;
    $display("%-20s %s, %0d errors", name,
             (error_count == errors_at_start) ? "ok" : "failed", error_count - errors_at_start);
    errors_at_start = error_count;
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic send_fields(input class_t cls, input command_code_t code,
                             input address_t addr, input size_t size);
    @(posedge clock);
    request_valid   <= 1'b1;
    request_class   <= cls;
    request_command <= code;
    request_address <= addr;
    request_size    <= size;
  endtask

  task automatic random_request(input class_t cls);
    send_fields(cls, command_code_t'(take_bits(13)), take_bits(64), size_t'(take_bits(12)));
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clock);
      request_valid <= 1'b0;
    end
  endtask

  // until every accepted request has come out
  task automatic drain();
    idle(1);
    @(negedge clock);  // scoreboard settled for this cycle
    while (outstanding() != 0) @(negedge clock);
    idle(2);
  endtask

  ////////////////////
  // reference model
  ////////////////////

  always_comb begin
    for (int c = 0; c < CLASS_COUNT; c++) begin
      issuing[c]       = command_valid && (command_tag[7:6] == class_t'(c));
      expected_full[c] = (model_count[c] - int'(issuing[c])) == QUEUE_DEPTH;
      accepting[c]     = request_valid && !expected_full[c] && (request_class == class_t'(c));
    end
  end

  assign expected_drop = request_valid && expected_full[request_class];

  task automatic accept_request();
    exp_code[request_class].push_back(request_command);
    exp_address[request_class].push_back(request_address);
    exp_size[request_class].push_back(request_size);
    exp_tag[request_class].push_back({request_class, seq_t'(seq_next[request_class])});
    seq_next[request_class] = (seq_next[request_class] + 1) % 64;  // six bit wrap
  endtask

  // four in a row must hold each class once
  task automatic check_window(input class_t cls);
    logic [CLASS_COUNT-1:0] seen;
    seen      = '0;
    seen[cls] = 1'b1;
    for (int i = 0; i < 3; i++) seen[fair_hist[i]] = 1'b1;
    if (fair_issues >= 3) begin
      assert (seen == '1) else report_failure("window of four issues misses a class");
    end
    fair_hist[2] = fair_hist[1];
    fair_hist[1] = fair_hist[0];
    fair_hist[0] = cls;
    fair_issues++;
  endtask

  task automatic check_issue();
    class_t cls;
    cls = command_tag[7:6];
    assert (exp_tag[cls].size() != 0)
      else report_failure($sformatf("tag %h issued with no request of its class", command_tag));
    if (exp_tag[cls].size() != 0) begin
      assert (command_code == exp_code[cls][0])
        else report_mismatch("command_code", command_code, exp_code[cls][0]);
      assert (command_address == exp_address[cls][0])
        else report_mismatch("command_address", command_address, exp_address[cls][0]);
      assert (command_size == exp_size[cls][0])
        else report_mismatch("command_size", command_size, exp_size[cls][0]);
      assert (command_tag == exp_tag[cls][0])
        else report_mismatch("command_tag", command_tag, exp_tag[cls][0]);
      void'(exp_code[cls].pop_front());
      void'(exp_address[cls].pop_front());
      void'(exp_size[cls].pop_front());
      void'(exp_tag[cls].pop_front());
    end
    if (fair_armed) check_window(cls);
  endtask

  // values read here are the ones of the cycle just ended
  always @(posedge clock) begin
    if (rstn) begin
      if (command_valid) check_issue();
      if (request_dropped) dropped_seen++;
      if (|accepting) accept_request();
      for (int c = 0; c < CLASS_COUNT; c++) begin
        model_count[c] <= model_count[c] - int'(issuing[c]) + int'(accepting[c]);
      end
    end
  end

  ////////////////////
  // bus checks
  ////////////////////

  a_reset_quiet : assert property (@(posedge clock)
    !rstn |-> (!command_valid && request_full == '0))
    else report_failure("command_valid or a full level high during reset");

  a_abt_strict : assert property (@(posedge clock) command_abt == STRICT)
    else report_mismatch("command_abt", $sampled(command_abt), STRICT);

  a_context_zero : assert property (@(posedge clock) command_context_handle == '0)
    else report_mismatch("command_context_handle", $sampled(command_context_handle), 0);

  a_tag_parity : assert property (@(posedge clock) disable iff (!rstn)
    command_valid |-> command_tag_parity == expect_parity(command_tag))
    else report_mismatch("command_tag_parity", $sampled(command_tag_parity),
                         expect_parity($sampled(command_tag)));

  a_code_parity : assert property (@(posedge clock) disable iff (!rstn)
    command_valid |-> command_code_parity == expect_parity(command_code))
    else report_mismatch("command_code_parity", $sampled(command_code_parity),
                         expect_parity($sampled(command_code)));

  a_address_parity : assert property (@(posedge clock) disable iff (!rstn)
    command_valid |-> command_address_parity == expect_parity(command_address))
    else report_mismatch("command_address_parity", $sampled(command_address_parity),
                         expect_parity($sampled(command_address)));

  a_pause : assert property (@(posedge clock) disable iff (!rstn)
    !enabled |=> !command_valid)
    else report_failure("command issued a cycle after enabled was low");

  a_full_level : assert property (@(posedge clock) disable iff (!rstn)
    request_full == expected_full)
    else report_mismatch("request_full", $sampled(request_full), $sampled(expected_full));

  a_drop : assert property (@(posedge clock) disable iff (!rstn)
    request_dropped == expected_drop)
    else report_mismatch("request_dropped", $sampled(request_dropped), $sampled(expected_drop));

  ////////////////////
  // tests
  ////////////////////

  initial begin
    lfsr_state      = 32'hc6c8_e929;
    rstn           <= 1'b0;
    request_valid   = 1'b0;
    request_class   = CLASS_RESTART;
    request_command = INVALID;
    request_address = '0;
    request_size    = '0;
    enabled         = 1'b0;
    fair_armed      = 1'b0;
    fair_issues     = 0;
    error_count     = 0;
    errors_at_start = 0;
    test_count      = 0;
    dropped_seen    = 0;
    repeat (3) @(posedge clock);
    rstn <= 1'b1;
    idle(2);
    finish_test("reset state");

    // sparse random traffic, about one request in four cycles
    enabled <= 1'b1;
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      if (take_bits(2) == 0) random_request(class_t'(take_bits(2)));
      else idle(1);
    end
    drain();
    finish_test("order and content");

    // corner patterns for the parity bits
    send_fields(CLASS_READ, READ_CL_NA, 64'hffff_ffff_ffff_ffff, 12'h080);
    send_fields(CLASS_WRITE, WRITE_NA, 64'h0, 12'h000);
    send_fields(CLASS_RESTART, RESTART, 64'h5555_5555_5555_5554, 12'h001);
    send_fields(CLASS_WED, 13'h1fff, 64'h8000_0000_0000_0001, 12'hfff);
    drain();
    finish_test("parity");

    // every queue full, then release
    enabled <= 1'b0;
    for (int r = 0; r < QUEUE_DEPTH; r++) begin
      for (int c = 0; c < CLASS_COUNT; c++) random_request(class_t'(c));
    end
    idle(1);
    @(negedge clock);
    assert (request_full == '1) else report_mismatch("request_full", request_full, 4'hf);
    @(posedge clock);
    fair_issues = 0;
    fair_armed <= 1'b1;
    enabled    <= 1'b1;
    drain();
    fair_armed <= 1'b0;
    finish_test("fairness");

    // fill the write queue, then offer one more
    enabled <= 1'b0;
    repeat (QUEUE_DEPTH) random_request(CLASS_WRITE);
    idle(1);
    @(negedge clock);
    assert (request_full[CLASS_WRITE]) else report_failure("write queue not full after four pushes");
    drops_before = dropped_seen;
    send_fields(CLASS_WRITE, WRITE_NA, 64'h0bad_0bad_0bad_0bad, 12'h040);
    idle(1);
    @(negedge clock);
    assert (dropped_seen == drops_before + 1)
      else report_failure("request to a full queue was not dropped");
    @(posedge clock);
    enabled <= 1'b1;
    drain();
    random_request(CLASS_WRITE);  // sequence carries on past the drop
    drain();
    finish_test("full and drop");

    // enabled falls in the middle of a burst
    for (int i = 0; i < 12; i++) begin
      if (i == 4) enabled <= 1'b0;
      random_request(class_t'(take_bits(2)));
    end
    idle(8);
    enabled <= 1'b1;
    drain();
    finish_test("pause");

    $display("%0d tests run, %0d errors", test_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("timeout: run still busy after %0d cycles", cycle_count);
    $display("TEST FAILED");
    $finish;
  end

endmodule
